/* source/forthCpuPkg.sv */
package forthCpuPkg;

	// basic widths of the register file datapath
	localparam int WORD_BITS = 16;
	localparam int BYTE_BITS = 8;
	localparam int BYTE_LANES = WORD_BITS / BYTE_BITS;
	localparam int INDEX_BITS = 4;

	// number of architectural registers, one per index value
	localparam int REG_COUNT = 1 << INDEX_BITS;

	// one machine word
	typedef logic [WORD_BITS-1:0] wordT;

	// byte lane enables, bit 0 selects the low byte and bit 1 the high byte
	typedef logic [BYTE_LANES-1:0] byteEnT;

	// register number as encoded in the instruction arguments
	typedef logic [INDEX_BITS-1:0] regIndexT;

	// fixed registers of the ISA register map
	// these are reached by the hardwired address selects on both ports
	localparam regIndexT RA = 4'd1;
	localparam regIndexT RB = 4'd2;
	localparam regIndexT RL = 4'd3;
	localparam regIndexT RSP = 4'd12;
	localparam regIndexT RFP = 4'd13;
	localparam regIndexT RRS = 4'd14;

	// port A address source
	// ARGA takes the index from the instruction, the rest are fixed registers
	typedef enum logic [1:0] {
		ARGA = 2'd0,
		REG_RA = 2'd1,
		REG_RB = 2'd2,
		REG_RL = 2'd3
	} regaAddrSelT;

	// port B address source
	// the RB literal carries a REGB prefix since enum literals share the package scope
	// with the port A select above
	typedef enum logic [2:0] {
		ARGB = 3'd0,
		REGB_RB = 3'd1,
		REG_RSP = 3'd2,
		REG_RFP = 3'd3,
		REG_RRS = 3'd4
	} regbAddrSelT;

	// port A write data source
	// DINH moves the high byte of the memory word into the low byte
	typedef enum logic [1:0] {
		DIN = 2'd0,
		DINH = 2'd1,
		PCANEXT = 2'd2,
		ALUR = 2'd3
	} regaDinSelT;

	// port A control as produced by the instruction decoder
	typedef struct packed {
		logic en;
		logic wen;
		regIndexT arg;
		regaAddrSelT addrSel;
		byteEnT byteEn;
		regaDinSelT dinSel;
	} portACtrlT;

	// port B control, which always writes the ALU result
	typedef struct packed {
		logic en;
		logic wen;
		regIndexT arg;
		regbAddrSelT addrSel;
		byteEnT byteEn;
	} portBCtrlT;

	// physical request to the register array after address and data steering
	typedef struct packed {
		logic en;
		logic wen;
		regIndexT addr;
		byteEnT byteEn;
		wordT wdata;
	} arrayPortT;

endpackage

/* source/registerSteering.sv */
module registerSteering import forthCpuPkg::*; (
	input portACtrlT portA,
	input portBCtrlT portB,
	input wordT aluR,
	input wordT din,
	input wordT pcANext,
	output arrayPortT arrayPortA,
	output arrayPortT arrayPortB
);

	// resolved addresses and write words for both ports
	regIndexT addrA;
	regIndexT addrB;
	wordT wdataA;
	wordT wdataB;

	// high byte of the memory word, placed in the low lane with zeros above
	wordT dinHigh;

	// byte loads from memory arrive in the upper half of din
	assign dinHigh = {{BYTE_BITS{1'b0}}, din[WORD_BITS-1 -: BYTE_BITS]};

	// port A address mux
	// the instruction argument is used unless a fixed register is named
	always_comb begin
		unique case (portA.addrSel)
			ARGA: begin
				addrA = portA.arg;
			end
			REG_RA: begin
				addrA = RA;
			end
			REG_RB: begin
				addrA = RB;
			end
			REG_RL: begin
				addrA = RL;
			end
			default: begin
				addrA = portA.arg;
			end
		endcase
	end

	// port A write data mux
	always_comb begin
		unique case (portA.dinSel)
			DIN: begin
				wdataA = din;
			end
			DINH: begin
				wdataA = dinHigh;
			end
			PCANEXT: begin
				// return address for calls
				wdataA = pcANext;
			end
			ALUR: begin
				wdataA = aluR;
			end
			default: begin
				wdataA = din;
			end
		endcase
	end

	// port B address mux
	// three encodings of the select are unused and fall back to the argument
	always_comb begin
		case (portB.addrSel)
			ARGB: begin
				addrB = portB.arg;
			end
			REGB_RB: begin
				addrB = RB;
			end
			REG_RSP: begin
				addrB = RSP;
			end
			REG_RFP: begin
				addrB = RFP;
			end
			REG_RRS: begin
				addrB = RRS;
			end
			default: begin
				addrB = portB.arg;
			end
		endcase
	end

	// port B only ever stores the ALU result
	assign wdataB = aluR;

	// assemble the physical requests
	// enables and byte lanes pass straight through from the decoder
	always_comb begin
		arrayPortA.en = portA.en;
		arrayPortA.wen = portA.wen;
		arrayPortA.addr = addrA;
		arrayPortA.byteEn = portA.byteEn;
		arrayPortA.wdata = wdataA;
	end

	always_comb begin
		arrayPortB.en = portB.en;
		arrayPortB.wen = portB.wen;
		arrayPortB.addr = addrB;
		arrayPortB.byteEn = portB.byteEn;
		arrayPortB.wdata = wdataB;
	end

endmodule

/* source/registerArray.sv */
module registerArray import forthCpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input arrayPortT arrayPortA,
	input arrayPortT arrayPortB,
	output wordT regaDout,
	output wordT regbDout
);

	// register storage and the contents it will hold after this edge
	wordT regs [REG_COUNT];
	wordT nextRegs [REG_COUNT];

	// qualified write strobes for each port
	logic writeA;
	logic writeB;

	// replace only the lanes whose enable bit is set
	function automatic wordT mergeLanes(
		input wordT oldWord,
		input wordT newWord,
		input byteEnT lanes
	);
		wordT merged;
		merged = oldWord;
		for (int lane = 0; lane < BYTE_LANES; lane++) begin
			if (lanes[lane]) begin
				merged[lane*BYTE_BITS +: BYTE_BITS] = newWord[lane*BYTE_BITS +: BYTE_BITS];
			end
		end
		return merged;
	endfunction

	// a port writes only when it is enabled and asks for a write
	assign writeA = arrayPortA.en && arrayPortA.wen;
	assign writeB = arrayPortB.en && arrayPortB.wen;

	// build the post-write image of the array
	// port A lanes go in first and port B lanes on top of them,
	// so B wins any lane that both ports write in the same register
	always_comb begin
		for (int i = 0; i < REG_COUNT; i++) begin
			nextRegs[i] = regs[i];
		end
		if (writeA) begin
			nextRegs[arrayPortA.addr] = mergeLanes(
				nextRegs[arrayPortA.addr],
				arrayPortA.wdata,
				arrayPortA.byteEn
			);
		end
		if (writeB) begin
			nextRegs[arrayPortB.addr] = mergeLanes(
				nextRegs[arrayPortB.addr],
				arrayPortB.wdata,
				arrayPortB.byteEn
			);
		end
	end

	// storage update
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= nextRegs[i];
			end
		end
	end

	// registered read ports
	// both read from the post-write image, which makes them write-first
	// and lets each port see the other port's write on the same edge
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			regaDout <= '0;
		end else if (arrayPortA.en) begin
			regaDout <= nextRegs[arrayPortA.addr];
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			regbDout <= '0;
		end else if (arrayPortB.en) begin
			regbDout <= nextRegs[arrayPortB.addr];
		end
	end

endmodule

/* source/registerFile.sv */
module registerFile import forthCpuPkg::*; (
	input logic CLK,
	input logic rstN,

	// datapath sources for the write ports
	input wordT aluR,
	input wordT din,
	input wordT pcANext,

	// decoder control for each port
	input portACtrlT portA,
	input portBCtrlT portB,

	// registered read data, valid one cycle after an enabled edge
	output wordT regaDout,
	output wordT regbDout
);

	// physical requests from the steering logic into the array
	arrayPortT arrayPortA;
	arrayPortT arrayPortB;

	// address and data selection, purely combinational
	registerSteering registerSteering_inst (
		.portA(portA),
		.portB(portB),
		.aluR(aluR),
		.din(din),
		.pcANext(pcANext),
		.arrayPortA(arrayPortA),
		.arrayPortB(arrayPortB)
	);

	// sixteen word storage with one cycle read latency
	registerArray registerArray_inst (
		.CLK(CLK),
		.rstN(rstN),
		.arrayPortA(arrayPortA),
		.arrayPortB(arrayPortB),
		.regaDout(regaDout),
		.regbDout(regbDout)
	);

endmodule

/* verification/registerFileTb.sv */
module registerFileTb import forthCpuPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// register map of the ISA as the reference model knows it
	localparam regIndexT IDX_RA = 4'd1;
	localparam regIndexT IDX_RB = 4'd2;
	localparam regIndexT IDX_RL = 4'd3;
	localparam regIndexT IDX_RSP = 4'd12;
	localparam regIndexT IDX_RFP = 4'd13;
	localparam regIndexT IDX_RRS = 4'd14;

	logic CLK;
	logic rstN;
	wordT aluR;
	wordT din;
	wordT pcANext;
	portACtrlT portA;
	portBCtrlT portB;
	wordT regaDout;
	wordT regbDout;

	// reference model of the sixteen registers and both read outputs
	wordT model [16];
	wordT expectA;
	wordT expectB;

	integer seed;
	int collisions;
	int crossReads;

	registerFile registerFile_inst (
		.CLK(CLK),
		.rstN(rstN),
		.aluR(aluR),
		.din(din),
		.pcANext(pcANext),
		.portA(portA),
		.portB(portB),
		.regaDout(regaDout),
		.regbDout(regbDout)
	);

	always #20 CLK = ~CLK;

	task automatic stopOnError();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic failWith(input string why);
		$display("[ERROR] time %0d ns: %s", $time, why);
		stopOnError();
	endtask

	task automatic checkValue(input wordT actual, input wordT expected, input string name);
		if (actual !== expected) begin
			$display("[ERROR] time %0d ns: %s is %h, expected %h",
				$time, name, actual, expected);
			stopOnError();
		end
	endtask

	// the clock level we wait for is never more than two toggles away
	task automatic waitEdge(input logic level);
		int guard;
		guard = 0;
		do begin
			@(CLK);
			guard++;
			if (guard > 3) begin
				failWith("the clock stopped toggling");
			end
		end while (CLK !== level);
	endtask

	function automatic wordT nextWord();
		return wordT'($random(seed));
	endfunction

	function automatic portACtrlT ctrlA(input logic en, input logic wen, input regIndexT arg,
		input regaAddrSelT sel, input byteEnT be, input regaDinSelT dsel);
		portACtrlT c;
		c.en = en;
		c.wen = wen;
		c.arg = arg;
		c.addrSel = sel;
		c.byteEn = be;
		c.dinSel = dsel;
		return c;
	endfunction

	function automatic portBCtrlT ctrlB(input logic en, input logic wen, input regIndexT arg,
		input regbAddrSelT sel, input byteEnT be);
		portBCtrlT c;
		c.en = en;
		c.wen = wen;
		c.arg = arg;
		c.addrSel = sel;
		c.byteEn = be;
		return c;
	endfunction

	function automatic regIndexT addrOfA(input portACtrlT c);
		case (c.addrSel)
			REG_RA: return IDX_RA;
			REG_RB: return IDX_RB;
			REG_RL: return IDX_RL;
			default: return c.arg;
		endcase
	endfunction

	function automatic regIndexT addrOfB(input portBCtrlT c);
		case (c.addrSel)
			REGB_RB: return IDX_RB;
			REG_RSP: return IDX_RSP;
			REG_RFP: return IDX_RFP;
			REG_RRS: return IDX_RRS;
			default: return c.arg;
		endcase
	endfunction

	// byte loads put the high memory byte in the low lane
	function automatic wordT dataOfA(input portACtrlT c);
		case (c.dinSel)
			DINH: return {8'h00, din[15:8]};
			PCANEXT: return pcANext;
			ALUR: return aluR;
			default: return din;
		endcase
	endfunction

	function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
		input byteEnT be);
		return {be[1] ? newWord[15:8] : oldWord[15:8], be[0] ? newWord[7:0] : oldWord[7:0]};
	endfunction

	// drives one request on the falling edge and checks both outputs one edge later
	task automatic driveCycle(input portACtrlT a, input portBCtrlT b, input wordT aluV,
		input wordT dinV, input wordT pcV);
		regIndexT addrA;
		regIndexT addrB;
		portA = a;
		portB = b;
		aluR = aluV;
		din = dinV;
		pcANext = pcV;
		addrA = addrOfA(a);
		addrB = addrOfB(b);
		// port B goes last so that it owns any lane both ports write
		if (a.en && a.wen) begin
			model[addrA] = mergeBytes(model[addrA], dataOfA(a), a.byteEn);
		end
		if (b.en && b.wen) begin
			model[addrB] = mergeBytes(model[addrB], aluV, b.byteEn);
		end
		if (a.en) begin
			expectA = model[addrA];
		end
		if (b.en) begin
			expectB = model[addrB];
		end
		if (a.en && a.wen && b.en && b.wen && addrA == addrB
			&& (a.byteEn & b.byteEn) != 2'b00) begin
			collisions++;
		end
		// a read only shows write-first when the other port really writes a lane
		if (a.en && b.en && addrA == addrB && a.wen != b.wen
			&& (a.wen ? a.byteEn : b.byteEn) != 2'b00) begin
			crossReads++;
		end
		waitEdge(1'b1);
		waitEdge(1'b0);
		checkValue(regaDout, expectA, "regaDout");
		checkValue(regbDout, expectB, "regbDout");
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		portA = '0;
		portB = '0;
		for (int i = 0; i < 16; i++) begin
			model[i] = '0;
		end
		expectA = '0;
		expectB = '0;
		repeat (10) begin
			waitEdge(1'b1);
		end
		waitEdge(1'b0);
		rstN = 1'b1;
	endtask

	task automatic testReset();
		checkValue(regaDout, 16'h0000, "regaDout after reset");
		checkValue(regbDout, 16'h0000, "regbDout after reset");
		for (int i = 0; i < 16; i++) begin
			driveCycle(ctrlA(1'b1, 1'b0, regIndexT'(i), ARGA, 2'b00, DIN),
				ctrlB(1'b1, 1'b0, regIndexT'(15 - i), ARGB, 2'b00), '0, '0, '0);
		end
	endtask

	task automatic testPortAWrites();
		regaDinSelT sel[4] = '{DIN, DINH, PCANEXT, ALUR};
		for (int i = 0; i < 4; i++) begin
			driveCycle(ctrlA(1'b1, 1'b1, regIndexT'(4 + i), ARGA, 2'b11, sel[i]),
				ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), nextWord(), nextWord(), nextWord());
		end
		driveCycle(ctrlA(1'b1, 1'b1, 4'd8, ARGA, 2'b11, DINH),
			ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), nextWord(), 16'h5678, nextWord());
		checkValue(regaDout, 16'h0056, "regaDout for a high byte load");
	endtask

	task automatic testPortAReads();
		regaAddrSelT sel[4] = '{ARGA, REG_RA, REG_RB, REG_RL};
		regIndexT target[4] = '{4'd5, IDX_RA, IDX_RB, IDX_RL};
		wordT written[4];
		for (int i = 0; i < 4; i++) begin
			written[i] = nextWord();
			driveCycle(ctrlA(1'b1, 1'b1, target[i], ARGA, 2'b11, ALUR),
				ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), written[i], '0, '0);
		end
		// fixed selects get arg 0 so that a wrong steering shows up
		for (int i = 0; i < 4; i++) begin
			driveCycle(ctrlA(1'b1, 1'b0, (i == 0) ? 4'd5 : 4'd0, sel[i], 2'b00, DIN),
				ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), nextWord(), '0, '0);
			checkValue(regaDout, written[i], "regaDout through a fixed select");
		end
	endtask

	task automatic testPortBWrites();
		regbAddrSelT sel[5] = '{ARGB, REGB_RB, REG_RSP, REG_RFP, REG_RRS};
		regIndexT target[5] = '{4'd9, IDX_RB, IDX_RSP, IDX_RFP, IDX_RRS};
		wordT written[5];
		for (int i = 0; i < 5; i++) begin
			written[i] = nextWord();
			driveCycle(ctrlA(1'b0, 1'b0, 4'd0, ARGA, 2'b00, DIN),
				ctrlB(1'b1, 1'b1, (i == 0) ? 4'd9 : 4'd0, sel[i], 2'b11),
				written[i], '0, '0);
			checkValue(regbDout, written[i], "regbDout on its own write");
		end
		for (int i = 0; i < 5; i++) begin
			driveCycle(ctrlA(1'b0, 1'b0, 4'd0, ARGA, 2'b00, DIN),
				ctrlB(1'b1, 1'b0, target[i], ARGB, 2'b00), nextWord(), '0, '0);
			checkValue(regbDout, written[i], "regbDout read back by index");
		end
	endtask

	task automatic testByteLanes();
		wordT held;
		driveCycle(ctrlA(1'b1, 1'b1, 4'd10, ARGA, 2'b11, ALUR),
			ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), 16'hA1B2, '0, '0);
		driveCycle(ctrlA(1'b1, 1'b1, 4'd10, ARGA, 2'b01, ALUR),
			ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), 16'h1234, '0, '0);
		checkValue(regaDout, 16'hA134, "regaDout after a low lane write");
		driveCycle(ctrlA(1'b1, 1'b1, 4'd10, ARGA, 2'b10, ALUR),
			ctrlB(1'b0, 1'b0, 4'd0, ARGB, 2'b00), 16'h5678, '0, '0);
		checkValue(regaDout, 16'h5634, "regaDout after a high lane write");
		driveCycle(ctrlA(1'b0, 1'b0, 4'd0, ARGA, 2'b00, DIN),
			ctrlB(1'b1, 1'b1, 4'd10, ARGB, 2'b01), 16'h00CD, '0, '0);
		checkValue(regbDout, 16'h56CD, "regbDout after a low lane write");
		held = regbDout;
		// port B is disabled but asks to write, so nothing may change on its side
		for (int i = 0; i < 3; i++) begin
			driveCycle(ctrlA(1'b1, 1'b1, regIndexT'(10 + i), ARGA, 2'b11, DIN),
				ctrlB(1'b0, 1'b1, 4'd10, ARGB, 2'b11), nextWord(), nextWord(), nextWord());
			checkValue(regbDout, held, "regbDout while its port is disabled");
		end
		held = regaDout;
		driveCycle(ctrlA(1'b0, 1'b1, 4'd11, ARGA, 2'b11, ALUR),
			ctrlB(1'b1, 1'b1, 4'd12, ARGB, 2'b11), nextWord(), '0, '0);
		checkValue(regaDout, held, "regaDout while its port is disabled");
	endtask

	task automatic testRandom();
		logic [31:0] r;
		portACtrlT a;
		portBCtrlT b;
		collisions = 0;
		crossReads = 0;
		for (int n = 0; n < 40; n++) begin
			r = $random(seed);
			a = ctrlA(r[0] | r[1], r[2], r[7:4], regaAddrSelT'(r[9:8]), r[11:10],
				regaDinSelT'(r[13:12]));
			b = ctrlB(r[14] | r[15], r[16], r[21:18], regbAddrSelT'(r[24:22] % 3'd5), r[26:25]);
			// three cycles in four put both ports on one register
			if (r[28:27] != 2'b11) begin
				b.addrSel = ARGB;
				b.arg = addrOfA(a);
				a.en = 1'b1;
				b.en = 1'b1;
			end
			if (r[28:27] == 2'b00) begin
				a.wen = 1'b1;
				b.wen = 1'b1;
				a.byteEn[r[29]] = 1'b1;
				b.byteEn[r[29]] = 1'b1;
			end else if (r[28:27] == 2'b01) begin
				a.wen = 1'b1;
				b.wen = 1'b0;
			end else if (r[28:27] == 2'b10) begin
				a.wen = 1'b0;
				b.wen = 1'b1;
			end
			driveCycle(a, b, nextWord(), nextWord(), nextWord());
		end
		if (collisions == 0) begin
			failWith("the random phase never had both ports write one register");
		end
		if (crossReads == 0) begin
			failWith("the random phase never read a register the other port was writing");
		end
	endtask

	initial begin
		seed = 32'h3836;
		CLK = 1'b0;
		rstN = 1'b0;
		aluR = '0;
		din = '0;
		pcANext = '0;
		portA = '0;
		portB = '0;
		applyReset();
		testReset();
		testPortAWrites();
		testPortAReads();
		testPortBWrites();
		testByteLanes();
		testRandom();
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* registerFile.f */
source/forthCpuPkg.sv
source/registerSteering.sv
source/registerArray.sv
source/registerFile.sv
verification/registerFileTb.sv

/* runSim.sh */
#!/bin/sh
# build the register file testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps -f registerFile.f \
	--top-module registerFileTb -o registerFileSim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/registerFileSim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
